// File: bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam int RESET_CYCLES  = 16;
  localparam int HIT_EDGES     = 2;      // Counted from the edge that presents the request
  localparam int PREFETCH_WAIT = 80;
  localparam int MAX_CYCLES    = 20000;  // Whole suite needs well under a thousand cycles

  logic       clock;
  logic       reset;
  logic       req_valid;
  fetch_req_t req;
  logic       rsp_ready;
  mem_rsp_t   mem_rsp;
  logic       req_ready;
  logic       rsp_valid;
  fetch_rsp_t rsp;
  mem_req_t   mem_req;

  integer seed;
  int     errors;
  int     model_errors;
  int     cycle_count = 0;

  icache_top i_icache_top (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_ready (rsp_ready),
    .mem_rsp   (mem_rsp),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .mem_req   (mem_req)
  );

  imem_model i_imem_model (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .errors  (model_errors)
  );

  always #10 clock = ~clock;   // 20 ns period

  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Line A holds the inverted A above A itself
  function automatic logic [DATA_W-1:0] expected_data(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] line;
    line = {addr[ADDR_W-1:3], 3'b000};
    return {~line, line};
  endfunction

  function automatic logic [ADDR_W-1:0] random_line();
    logic [ADDR_W-1:0] addr;
    addr = $random(seed);
    return {addr[ADDR_W-1:3], 3'b000};
  endfunction

  task automatic check_rsp(input string test, input logic [ADDR_W-1:0] addr,
                           input fetch_rsp_t got);
    if (got.addr !== addr)
    begin
      errors++;
      $display("FAILED %s: rsp.addr expected %h, actual %h", test, addr, got.addr);
    end
    if (got.data !== expected_data(addr))
    begin
      errors++;
      $display("FAILED %s: rsp.data expected %h, actual %h", test, expected_data(addr),
               got.data);
    end
  endtask

  task automatic check_hit_edges(input string test, input int edges);
    if (edges != HIT_EDGES)
    begin
      errors++;
      $display("FAILED %s: response edges expected %0d, actual %0d", test, HIT_EDGES, edges);
    end
  endtask

  // Presents one fetch and returns its response once rsp_valid is seen
  task automatic fetch_line(input logic [ADDR_W-1:0] addr, output int edges,
                            output fetch_rsp_t got);
    edges = 0;
    @(posedge clock);
    req_valid <= 1'b1;
    req.addr  <= addr;
    @(negedge clock);
    while (!req_ready)
    begin
      @(negedge clock);
      edges++;
    end
    @(posedge clock);   // Transfer edge
    edges++;
    req_valid <= 1'b0;
    @(negedge clock);
    while (!rsp_valid)
    begin
      @(negedge clock);
      edges++;
    end
    got = rsp;
  endtask

  task automatic check_after_reset();
    @(negedge clock);
    if (rsp_valid !== 1'b0)
    begin
      errors++;
      $display("FAILED after_reset: rsp_valid expected 0, actual %b", rsp_valid);
    end
    if (req_ready !== 1'b1)
    begin
      errors++;
      $display("FAILED after_reset: req_ready expected 1, actual %b", req_ready);
    end
  endtask

  task automatic test_cold_miss(output logic [ADDR_W-1:0] addr);
    int         edges;
    fetch_rsp_t got;
    addr = random_line();
    fetch_line(addr, edges, got);
    check_rsp("cold_miss", addr, got);
  endtask

  task automatic test_hit_timing(input logic [ADDR_W-1:0] addr);
    int         edges;
    fetch_rsp_t got;
    fetch_line(addr, edges, got);
    check_rsp("hit_timing", addr, got);
    check_hit_edges("hit_timing", edges);
  endtask

  task automatic test_prefetch();
    logic [ADDR_W-1:0] base;
    int                edges;
    fetch_rsp_t        got;
    base = random_line();
    fetch_line(base, edges, got);
    check_rsp("prefetch", base, got);
    repeat (PREFETCH_WAIT) @(posedge clock);
    for (int k = 1; k <= PREFETCH_DEPTH; k++)
    begin
      fetch_line(base + ADDR_W'(LINE_BYTES * k), edges, got);
      check_rsp("prefetch", base + ADDR_W'(LINE_BYTES * k), got);
      check_hit_edges("prefetch", edges);
    end
  endtask

  task automatic test_backpressure();
    logic [ADDR_W-1:0] addr;
    int                edges;
    int                hold;
    fetch_rsp_t        got;
    addr = random_line();
    hold = 1 + int'($unsigned($random(seed)) % 32'd20);
    @(posedge clock);
    rsp_ready <= 1'b0;
    fetch_line(addr, edges, got);
    repeat (hold)
    begin
      @(negedge clock);
      if (rsp_valid !== 1'b1)
      begin
        errors++;
        $display("FAILED backpressure: rsp_valid expected 1, actual %b", rsp_valid);
      end
      if (rsp !== got)
      begin
        errors++;
        $display("FAILED backpressure: rsp expected %h, actual %h", got, rsp);
      end
      if (req_ready !== 1'b0)
      begin
        errors++;
        $display("FAILED backpressure: req_ready expected 0, actual %b", req_ready);
      end
    end
    @(posedge clock);
    rsp_ready <= 1'b1;
    @(posedge clock);   // Response taken here
    @(negedge clock);
    if (rsp_valid || !req_ready)
    begin
      errors++;
      $display("Back-pressure: response was not taken after rsp_ready rose");
    end
    check_rsp("backpressure", addr, got);
  endtask

  task automatic test_conflict();
    logic [ADDR_W-1:0] first;
    logic [ADDR_W-1:0] second;
    int                edges;
    fetch_rsp_t        got;
    first  = random_line();
    second = first + 32'd256;   // Same index, other tag
    fetch_line(first, edges, got);
    check_rsp("conflict", first, got);
    fetch_line(second, edges, got);
    check_rsp("conflict", second, got);
    fetch_line(first, edges, got);
    check_rsp("conflict", first, got);
  endtask

  initial
  begin
    logic [ADDR_W-1:0] cold_addr;
    seed      = 32'h860f_d9a3;
    errors    = 0;
    clock     = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    check_after_reset();
    test_cold_miss(cold_addr);
    test_hit_timing(cold_addr);
    test_prefetch();
    test_backpressure();
    test_conflict();
    repeat (10) @(posedge clock);
    $display("Errors: %0d in bench checks, %0d in memory model", errors, model_errors);
    if ((errors + model_errors) == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: bench/imem_model.sv
`timescale 1ns/1ps

module imem_model
  import icache_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp,
  output int       errors
);

  localparam int LATENCY = 4;   // Cycles from acceptance to the data beat

  typedef struct packed {
    logic [MEM_TAG_W-1:0] tag;
    logic [ADDR_W-1:0]    addr;
  } return_t;

  integer                seed = 32'h860f_d9a3;
  int                    err_count = 0;
  logic [NUM_MEM_TAGS:0] busy;          // Tags waiting for their data beat
  logic [MEM_TAG_W-1:0]  free_tag;
  logic                  accept;        // Coin for this cycle, drawn on the previous edge
  return_t               pipe [LATENCY];

  function automatic logic [DATA_W-1:0] line_word(input logic [ADDR_W-1:0] line);
    return {~line, line};
  endfunction

  // Lowest tag not in flight, zero when all are taken
  always_comb
  begin
    free_tag = '0;
    for (int t = NUM_MEM_TAGS; t >= 1; t--)
    begin
      if (!busy[t])
        free_tag = MEM_TAG_W'(t);
    end
  end

  assign mem_rsp.response = (mem_req.command == BUS_LOAD && accept) ? free_tag : '0;
  assign mem_rsp.tag      = pipe[LATENCY-1].tag;
  assign mem_rsp.data     = (pipe[LATENCY-1].tag != '0) ? line_word(pipe[LATENCY-1].addr) : '0;
  assign errors           = err_count;

  always @(posedge clock)
  begin
    if (reset)
    begin
      busy   <= '0;
      accept <= 1'b0;
      for (int i = 0; i < LATENCY; i++)
        pipe[i] <= '0;
      if (mem_req.command != BUS_NONE)
      begin
        err_count <= err_count + 1;
        $display("Memory model: load command seen while reset was held");
      end
    end
    else
    begin
      accept  <= ($random(seed) % 4) != 0;   // Three out of four requests accepted
      pipe[0] <= {mem_rsp.response, mem_req.addr};
      for (int i = 1; i < LATENCY; i++)
        pipe[i] <= pipe[i-1];
      if (pipe[LATENCY-1].tag != '0)
        busy[pipe[LATENCY-1].tag] <= 1'b0;
      if (mem_rsp.response != '0)
        busy[mem_rsp.response] <= 1'b1;
    end
  end

endmodule

// File: flist.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_mem.sv
hw/fetch_fsm.sv
hw/prefetch_window.sv
hw/icache_top.sv
bench/imem_model.sv
bench/icache_tb.sv

// File: hw/fetch_fsm.sv
`timescale 1ns/1ps

module fetch_fsm
  import icache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  fetch_req_t        req,
  input  logic              rsp_ready,
  input  logic              hit_valid,
  input  logic [DATA_W-1:0] hit_data,
  output logic              req_ready,
  output logic              rsp_valid,
  output fetch_rsp_t        rsp,
  output logic [ADDR_W-1:0] lookup_addr,
  output logic              lookup_active,
  output logic              restart
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    LOOKUP  = 2'd1,
    RESPOND = 2'd2
  } state_e;

  state_e            state;
  logic [ADDR_W-1:0] addr_q;   // Accepted fetch address
  fetch_rsp_t        rsp_q;

  assign req_ready     = (state == IDLE);
  assign rsp_valid     = (state == RESPOND);
  assign lookup_active = (state == LOOKUP);
  assign lookup_addr   = addr_q;
  assign rsp           = rsp_q;
  assign restart       = req_valid && req_ready;  // New demand fetch

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= IDLE;
    end
    else
    begin
      case (state)
        IDLE:
          if (req_valid)
            state <= LOOKUP;
        LOOKUP:
          if (hit_valid)
            state <= RESPOND;
        RESPOND:
          if (rsp_ready)
            state <= IDLE;  // Response taken
        default:
          state <= IDLE;
      endcase
    end
  end

  // Address and response payload
  always_ff @(posedge clock)
  begin
    if (restart)
      addr_q <= req.addr;
    if (lookup_active && hit_valid)
    begin
      rsp_q.addr <= addr_q;
      rsp_q.data <= hit_data;
    end
  end

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic [ADDR_W-1:0] lookup_addr,
  input  logic              lookup_active,
  input  mem_rsp_t          mem_rsp,
  input  logic [DATA_W-1:0] rd_data,
  input  logic              rd_valid,
  input  logic              stall,
  output mem_req_t          mem_req,
  output logic              hit_valid,
  output logic [DATA_W-1:0] hit_data,
  output cache_wr_t         cache_wr,
  output logic              wr_en,
  output logic              issue
);

  logic [NUM_MEM_TAGS:0] tag_valid;                 // Bit 0 is never set
  logic [ADDR_W-1:0]     tag_addr [NUM_MEM_TAGS:0]; // Line requested under each tag
  logic [ADDR_W-1:0]     prefetch_addr;             // Last line sent to memory
  logic [ADDR_W-1:0]     demand_line;
  logic [ADDR_W-1:0]     next_addr;
  logic [ADDR_W-1:0]     return_line;
  logic                  demand_pending;
  logic                  forward;

  assign demand_line = {lookup_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign return_line = tag_addr[mem_rsp.tag];

  // Is the demand line already on its way from memory
  always_comb
  begin
    demand_pending = 1'b0;
    for (int t = 1; t <= NUM_MEM_TAGS; t++)
    begin
      if (tag_valid[t] && (tag_addr[t] == demand_line))
        demand_pending = 1'b1;
    end
  end

  // Demand line first, otherwise keep walking ahead
  assign next_addr = (lookup_active && !rd_valid && !demand_pending)
                     ? demand_line
                     : prefetch_addr + ADDR_W'(LINE_BYTES);

  assign mem_req.command = reset ? BUS_NONE : BUS_LOAD;
  assign mem_req.addr    = next_addr;

  assign issue = (mem_rsp.response != '0) && !stall;

  // Returning data for a tag we own goes into the line store
  assign wr_en          = tag_valid[mem_rsp.tag];
  assign cache_wr.index = return_line[OFFSET_BITS +: IDX_BITS];
  assign cache_wr.tag   = return_line[ADDR_W-1 -: TAG_BITS];
  assign cache_wr.data  = mem_rsp.data;

  // Same data answers the lookup in the cycle it arrives
  assign forward   = wr_en && (return_line == demand_line);
  assign hit_valid = lookup_active && (rd_valid || forward);
  assign hit_data  = forward ? mem_rsp.data : rd_data;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      tag_valid     <= '0;
      prefetch_addr <= '0;
    end
    else
    begin
      if (wr_en)
        tag_valid[mem_rsp.tag] <= 1'b0;      // Tag retires on its data beat
      if (issue)
      begin
        tag_valid[mem_rsp.response] <= 1'b1; // Wins over a retire of the same tag
        prefetch_addr               <= next_addr;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (issue)
      tag_addr[mem_rsp.response] <= next_addr;
  end

endmodule

// File: hw/icache_mem.sv
`timescale 1ns/1ps

module icache_mem
  import icache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  cache_wr_t         cache_wr,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] lookup_addr,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_valid
);

  logic [DATA_W-1:0]    line_data [NUM_LINES];
  logic [TAG_BITS-1:0]  line_tag  [NUM_LINES];
  logic [NUM_LINES-1:0] line_valid;

  logic [IDX_BITS-1:0]  rd_index;
  logic [TAG_BITS-1:0]  rd_tag;

  // Split the lookup address into index and tag
  assign rd_index = lookup_addr[OFFSET_BITS +: IDX_BITS];
  assign rd_tag   = lookup_addr[ADDR_W-1 -: TAG_BITS];

  // Combinational read
  assign rd_data  = line_data[rd_index];
  assign rd_valid = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      line_valid <= '0;
    end
    else if (wr_en)
    begin
      line_valid[cache_wr.index] <= 1'b1;
    end
  end

  // Line contents and tags
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      line_data[cache_wr.index] <= cache_wr.data;
      line_tag[cache_wr.index]  <= cache_wr.tag;   // Replaces whatever lived at this index
    end
  end

endmodule

// File: hw/icache_pkg.sv
package icache_pkg;

  // Address and line geometry
  localparam int ADDR_W      = 32;
  localparam int LINE_BYTES  = 8;                               // One 64-bit word per line
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int DATA_W      = 64;
  localparam int IDX_BITS    = 5;
  localparam int NUM_LINES   = 1 << IDX_BITS;
  localparam int TAG_BITS    = ADDR_W - IDX_BITS - OFFSET_BITS; // 24 bits

  // Memory tags, tag 0 means no tag
  localparam int NUM_MEM_TAGS = 15;
  localparam int MEM_TAG_W    = 4;

  // Prefetch window, one demand line plus the prefetch lines
  localparam int PREFETCH_DEPTH = 4;
  localparam int WIN_LIMIT      = PREFETCH_DEPTH + 1;
  localparam int WIN_CNT_W      = $clog2(WIN_LIMIT + 1);

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_e;

  // Processor side
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // Address of the fetch being answered
    logic [DATA_W-1:0] data;
  } fetch_rsp_t;

  // Memory side
  typedef struct packed {
    bus_cmd_e          command;
    logic [ADDR_W-1:0] addr;   // Line aligned
  } mem_req_t;

  typedef struct packed {
    logic [MEM_TAG_W-1:0] response; // Same cycle answer, zero when refused
    logic [MEM_TAG_W-1:0] tag;      // Tag of returning data, zero when idle
    logic [DATA_W-1:0]    data;
  } mem_rsp_t;

  // Write port of the line store
  typedef struct packed {
    logic [IDX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;
    logic [DATA_W-1:0]   data;
  } cache_wr_t;

endpackage

// File: hw/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid,
  input  fetch_req_t req,
  input  logic       rsp_ready,
  input  mem_rsp_t   mem_rsp,
  output logic       req_ready,
  output logic       rsp_valid,
  output fetch_rsp_t rsp,
  output mem_req_t   mem_req
);

  logic [ADDR_W-1:0] lookup_addr;
  logic              lookup_active;
  logic              hit_valid;
  logic [DATA_W-1:0] hit_data;
  cache_wr_t         cache_wr;
  logic              wr_en;
  logic [DATA_W-1:0] rd_data;
  logic              rd_valid;
  logic              issue;
  logic              restart;
  logic              window_full;

  icache_ctrl i_icache_ctrl (
    .clock         (clock),
    .reset         (reset),
    .lookup_addr   (lookup_addr),
    .lookup_active (lookup_active),
    .mem_rsp       (mem_rsp),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .stall         (window_full),   // Window full holds off issuing
    .mem_req       (mem_req),
    .hit_valid     (hit_valid),
    .hit_data      (hit_data),
    .cache_wr      (cache_wr),
    .wr_en         (wr_en),
    .issue         (issue)
  );

  icache_mem i_icache_mem (
    .clock       (clock),
    .reset       (reset),
    .cache_wr    (cache_wr),
    .wr_en       (wr_en),
    .lookup_addr (lookup_addr),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid)
  );

  fetch_fsm i_fetch_fsm (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .rsp_ready     (rsp_ready),
    .hit_valid     (hit_valid),
    .hit_data      (hit_data),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .lookup_addr   (lookup_addr),
    .lookup_active (lookup_active),
    .restart       (restart)
  );

  prefetch_window i_prefetch_window (
    .clock   (clock),
    .reset   (reset),
    .issue   (issue),
    .restart (restart),
    .full    (window_full)
  );

endmodule

// File: hw/prefetch_window.sv
`timescale 1ns/1ps

module prefetch_window
  import icache_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic issue,
  input  logic restart,
  output logic full
);

  logic [WIN_CNT_W-1:0] count;   // Lines issued since the last demand fetch

  assign full = (count == WIN_CNT_W'(WIN_LIMIT));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (restart)
    begin
      count <= '0;  // Fresh window for the new demand line
    end
    else if (issue && !full)
    begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it, and judge the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module icache_tb -f flist.f -o icache_sim \
  || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/icache_sim)
echo "$sim_out"
echo "$sim_out" | grep -qxF '>>> PASS' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
